/* logic/cpuPkg.sv */
// Widths, ALU opcodes and instruction field positions shared by every datapath block
package cpuPkg;

   // Data and bus width
   localparam int wordWidth = 32;

   // Register file size and index width
   localparam int regCount = 16;
   localparam int regIdxWidth = 4;

   // RAM depth, address width and read latency in cycles
   localparam int memDepth = 512;
   localparam int memAddrWidth = $clog2(memDepth);
   localparam int memLatency = 2;

   // Register fields in the instruction word
   localparam int raMsb = 26;
   localparam int raLsb = 23;
   localparam int rbMsb = 22;
   localparam int rbLsb = 19;
   localparam int rcMsb = 18;
   localparam int rcLsb = 15;

   // Sign-extended constant sits in the low bits
   localparam int immMsb = 18;

   // ALU operation select, six bits as on the control bus
   typedef enum logic [5:0] {
      opAdd,
      opSub,
      opAnd,
      opOr,
      opShl,
      opShr,
      opNeg,
      opNot,
      opMul
   } aluOp;

endpackage

/* logic/datapathIfs.sv */
// Register-select and memory-port bundles between the datapath top level and its blocks
`timescale 1ns/1ps

interface regSelIf;
   import cpuPkg::*;

   // Field select and transfer strobes
   logic gra, grb, grc;
   logic rin, rout, baOut;
   logic [wordWidth-1:0] ir;
   logic [wordWidth-1:0] busIn;
   // Selected register, or zero when nothing reads
   logic [wordWidth-1:0] rfData;

   modport master (output gra, grb, grc, rin, rout, baOut, ir, busIn, input rfData);
   modport slave (input gra, grb, grc, rin, rout, baOut, ir, busIn, output rfData);
endinterface

interface memPortIf;
   import cpuPkg::*;

   logic read, write;
   logic marIn, mdrIn;
   logic [wordWidth-1:0] busIn;
   logic [wordWidth-1:0] mdrData;
   logic [wordWidth-1:0] marData;
   // One-cycle completion pulse for reads and writes
   logic done;

   modport master (output read, write, marIn, mdrIn, busIn,
                   input mdrData, marData, done);
   modport slave (input read, write, marIn, mdrIn, busIn,
                  output mdrData, marData, done);
endinterface

/* logic/registerFile.sv */
// Sixteen general registers addressed through the Ra, Rb or Rc field of the instruction
`timescale 1ns/1ps

module registerFile (
   input logic     Clock,
   input logic     rst,
   regSelIf.slave  regs
);
   import cpuPkg::*;

   logic [wordWidth-1:0]   regArray [regCount];
   logic [regIdxWidth-1:0] selIdx;

   // Ra wins over Rb, Rb over Rc
   always_comb begin
      if (regs.gra) begin
         selIdx = regs.ir[raMsb:raLsb];
      end else if (regs.grb) begin
         selIdx = regs.ir[rbMsb:rbLsb];
      end else if (regs.grc) begin
         selIdx = regs.ir[rcMsb:rcLsb];
      end else begin
         selIdx = '0;
      end
   end

   always_ff @(posedge Clock) begin
      if (rst) begin
         for (int i = 0; i < regCount; i++) begin
            regArray[i] <= '0;
         end
      end else if (regs.rin) begin
         regArray[selIdx] <= regs.busIn;
      end
   end

   // Base addressing treats R0 as a constant zero
   always_comb begin
      if (regs.baOut && selIdx == '0) begin
         regs.rfData = '0;
      end else if (regs.rout || regs.baOut) begin
         regs.rfData = regArray[selIdx];
      end else begin
         regs.rfData = '0;
      end
   end

endmodule

/* logic/aluUnit.sv */
// ALU with single-cycle logic and arithmetic ops and a multi-cycle unsigned multiplier
`timescale 1ns/1ps

module aluUnit (
   input  logic                         Clock,
   input  logic                         rst,
   input  logic                         start,
   input  cpuPkg::aluOp                 opSelect,
   input  logic [cpuPkg::wordWidth-1:0] operandA,
   input  logic [cpuPkg::wordWidth-1:0] operandB,
   output logic [cpuPkg::wordWidth-1:0] resultLo,
   output logic [cpuPkg::wordWidth-1:0] resultHi,
   output logic                         finished
);
   import cpuPkg::*;

   logic [wordWidth-1:0]   simpleResult;
   logic                   busy;
   logic                   mulLoad;
   logic [4:0]             stepCount;
   logic [wordWidth-1:0]   multiplicand;
   logic [2*wordWidth-1:0] product;
   logic [wordWidth:0]     partialSum;
   logic [2*wordWidth-1:0] productNext;

   // Unary ops act on the bus operand
   always_comb begin
      case (opSelect)
         opAdd:   simpleResult = operandA + operandB;
         opSub:   simpleResult = operandA - operandB;
         opAnd:   simpleResult = operandA & operandB;
         opOr:    simpleResult = operandA | operandB;
         opShl:   simpleResult = operandA << operandB[4:0];
         opShr:   simpleResult = operandA >> operandB[4:0];
         opNeg:   simpleResult = -operandB;
         opNot:   simpleResult = ~operandB;
         default: simpleResult = '0;
      endcase
   end

   assign mulLoad = start && !busy && opSelect == opMul;

   // One shift-add step, carry kept in the top bit of the partial sum
   assign partialSum = {1'b0, product[2*wordWidth-1:wordWidth]}
                     + (product[0] ? {1'b0, multiplicand} : {(wordWidth+1){1'b0}});
   assign productNext = {partialSum, product[wordWidth-1:1]};

   always_ff @(posedge Clock) begin
      if (mulLoad) begin
         multiplicand <= operandA;
         product <= {{wordWidth{1'b0}}, operandB};
      end else if (busy) begin
         product <= productNext;
      end
   end

   always_ff @(posedge Clock) begin
      if (rst) begin
         busy <= 1'b0;
         finished <= 1'b0;
         stepCount <= '0;
         resultLo <= '0;
         resultHi <= '0;
      end else begin
         finished <= 1'b0;
         if (busy) begin
            stepCount <= stepCount + 1'b1;
            // Last of the 32 steps
            if (stepCount == 5'd31) begin
               busy <= 1'b0;
               finished <= 1'b1;
               resultHi <= productNext[2*wordWidth-1:wordWidth];
               resultLo <= productNext[wordWidth-1:0];
            end
         end else if (mulLoad) begin
            busy <= 1'b1;
            stepCount <= '0;
         end else if (start) begin
            resultLo <= simpleResult;
            resultHi <= '0;
            finished <= 1'b1;
         end
      end
   end

endmodule

/* logic/memoryUnit.sv */
// MAR, MDR and word RAM with a fixed-latency read and a one-edge write
`timescale 1ns/1ps

module memoryUnit (
   input logic     Clock,
   input logic     rst,
   memPortIf.slave mem
);
   import cpuPkg::*;

   logic [wordWidth-1:0]    ram [memDepth];
   logic [wordWidth-1:0]    mar;
   logic [wordWidth-1:0]    mdr;
   logic [wordWidth-1:0]    ramQ;
   logic [memAddrWidth-1:0] readAddr;
   logic                    readPrev, writePrev;
   logic [1:0]              readCount;
   logic                    readStart, writeStart, readDone;

   // Only the first cycle of a held strobe starts an access
   assign readStart = mem.read && !readPrev && readCount == '0;
   assign writeStart = mem.write && !writePrev;
   assign readDone = readCount == 2'(memLatency - 1);

   // A MAR load in the read cycle is forwarded to the RAM
   assign readAddr = mem.marIn ? mem.busIn[memAddrWidth-1:0] : mar[memAddrWidth-1:0];

   always_ff @(posedge Clock) begin
      if (writeStart && !rst) begin
         ram[mar[memAddrWidth-1:0]] <= mdr;
      end
      if (readStart) begin
         ramQ <= ram[readAddr];
      end
   end

   always_ff @(posedge Clock) begin
      if (rst) begin
         readPrev <= 1'b0;
         writePrev <= 1'b0;
         readCount <= '0;
         mem.done <= 1'b0;
         mar <= '0;
         mdr <= '0;
      end else begin
         readPrev <= mem.read;
         writePrev <= mem.write;
         mem.done <= readDone || writeStart;
         if (readDone) begin
            readCount <= '0;
         end else if (readStart || readCount != '0) begin
            readCount <= readCount + 1'b1;
         end
         if (mem.marIn) begin
            mar <= mem.busIn;
         end
         // RAM data on completion, bus data when no read is pending
         if (readDone && mem.mdrIn) begin
            mdr <= ramQ;
         end else if (mem.mdrIn && !mem.read && readCount == '0) begin
            mdr <= mem.busIn;
         end
      end
   end

   assign mem.mdrData = mdr;
   assign mem.marData = mar;

endmodule

/* logic/dataPath.sv */
// Single-bus datapath top level, stepped one cycle at a time by external control strobes
`timescale 1ns/1ps

module dataPath (
   input  logic                         Clock,
   input  logic                         rst,
   // Bus sources, highest priority first
   input  logic                         extIn, rfOut, pcOut, irOut,
   input  logic                         ryOut, rzLoOut, rzHiOut, marOut,
   input  logic                         hiOut, loOut, immOut, mdrOut,
   // Register loads from the bus
   input  logic                         pcIn, irIn, ryIn, rzIn,
   input  logic                         marIn, hiIn, loIn, mdrIn,
   // Register file control
   input  logic                         gra, grb, grc,
   input  logic                         rin, rout, baOut,
   input  logic                         incPc,
   input  logic                         read,
   input  logic                         write,
   input  logic                         start,
   input  cpuPkg::aluOp                 opSelect,
   input  logic [cpuPkg::wordWidth-1:0] extData,
   output logic                         finished,
   output logic                         memFinished,
   output logic [cpuPkg::wordWidth-1:0] busValue
);
   import cpuPkg::*;

   logic [wordWidth-1:0]   bus;
   logic [wordWidth-1:0]   pc, ir, ry, hi, lo;
   logic [2*wordWidth-1:0] rz;
   logic [wordWidth-1:0]   immValue;
   logic [wordWidth-1:0]   aluLo, aluHi;
   logic                   rfSelOut;

   regSelIf regs ();
   memPortIf memPort ();

   assign regs.gra = gra;
   assign regs.grb = grb;
   assign regs.grc = grc;
   assign regs.rin = rin;
   assign regs.rout = rout || rfOut;
   assign regs.baOut = baOut;
   assign regs.ir = ir;
   assign regs.busIn = bus;

   assign memPort.read = read;
   assign memPort.write = write;
   assign memPort.marIn = marIn;
   assign memPort.mdrIn = mdrIn;
   assign memPort.busIn = bus;

   registerFile regFile (.Clock(Clock), .rst(rst), .regs(regs));

   aluUnit alu (
      .Clock(Clock), .rst(rst), .start(start), .opSelect(opSelect),
      .operandA(ry), .operandB(bus),
      .resultLo(aluLo), .resultHi(aluHi), .finished(finished)
   );

   memoryUnit memory (.Clock(Clock), .rst(rst), .mem(memPort));

   // Any register file read strobe claims the bus at the rfOut slot
   assign rfSelOut = rfOut || rout || baOut;
   assign immValue = {{(wordWidth-immMsb-1){ir[immMsb]}}, ir[immMsb:0]};

   always_comb begin
      if (extIn) bus = extData;
      else if (rfSelOut) bus = regs.rfData;
      else if (pcOut) bus = pc;
      else if (irOut) bus = ir;
      else if (ryOut) bus = ry;
      else if (rzLoOut) bus = rz[wordWidth-1:0];
      else if (rzHiOut) bus = rz[2*wordWidth-1:wordWidth];
      else if (marOut) bus = memPort.marData;
      else if (hiOut) bus = hi;
      else if (loOut) bus = lo;
      else if (immOut) bus = immValue;
      else if (mdrOut) bus = memPort.mdrData;
      else bus = '0;
   end

   always_ff @(posedge Clock) begin
      if (rst) begin
         pc <= '0;
         ir <= '0;
         ry <= '0;
         rz <= '0;
         hi <= '0;
         lo <= '0;
      end else begin
         if (pcIn) begin
            pc <= bus;
         end else if (incPc) begin
            pc <= pc + 1'b1;
         end
         if (irIn) ir <= bus;
         if (ryIn) ry <= bus;
         // RZ takes both ALU halves on the completion cycle
         if (finished && rzIn) rz <= {aluHi, aluLo};
         if (hiIn) hi <= bus;
         if (loIn) lo <= bus;
      end
   end

   assign memFinished = memPort.done;
   assign busValue = bus;

endmodule

/* bench/dataPath_props.sv */
// Bus and completion-timing assertions, bound into every dataPath instance for simulation
`timescale 1ns/1ps

module dataPathProps (
   input logic                         Clock,
   input logic                         rst,
   input logic                         extIn, rfOut, pcOut, irOut,
   input logic                         ryOut, rzLoOut, rzHiOut, marOut,
   input logic                         hiOut, loOut, immOut, mdrOut,
   input logic                         rout, baOut,
   input logic                         read, write, start,
   input cpuPkg::aluOp                 opSelect,
   input logic [cpuPkg::wordWidth-1:0] extData,
   input logic [cpuPkg::wordWidth-1:0] busValue,
   input logic                         finished,
   input logic                         memFinished
);
   import cpuPkg::*;

   // Read by the testbench to end the run on any failure
   int failCount = 0;
   logic anyOut;

   assign anyOut = extIn | rfOut | rout | baOut | pcOut | irOut | ryOut | rzLoOut
                 | rzHiOut | marOut | hiOut | loOut | immOut | mdrOut;

   extOnBus: assert property (@(posedge Clock) disable iff (rst)
      extIn |-> busValue == extData)
      else begin
         $error("bus does not carry the external data");
         failCount++;
      end

   idleBusZero: assert property (@(posedge Clock) disable iff (rst)
      !anyOut |-> busValue == '0)
      else begin
         $error("bus is not zero with no source selected");
         failCount++;
      end

   simpleOpDone: assert property (@(posedge Clock) disable iff (rst)
      start && opSelect != opMul |=> finished)
      else begin
         $error("single-cycle ALU op did not finish on the next cycle");
         failCount++;
      end

   // 32 shift-add steps and the load cycle
   mulDone: assert property (@(posedge Clock) disable iff (rst)
      start && opSelect == opMul |-> ##33 finished)
      else begin
         $error("multiply did not finish after 33 cycles");
         failCount++;
      end

   readDone: assert property (@(posedge Clock) disable iff (rst)
      $rose(read) |-> ##memLatency memFinished)
      else begin
         $error("memory read did not complete after the fixed latency");
         failCount++;
      end

   writeDone: assert property (@(posedge Clock) disable iff (rst)
      $rose(write) |=> memFinished)
      else begin
         $error("memory write did not complete on the next cycle");
         failCount++;
      end

   resetQuiet: assert property (@(posedge Clock)
      rst |=> !finished && !memFinished)
      else begin
         $error("completion flag high right after reset");
         failCount++;
      end

endmodule

bind dataPath dataPathProps props (.*);

/* bench/dataPathTb.sv */
// Testbench for the datapath top level, steps control strobes and checks the bus against a model
`timescale 1ns/1ps

module dataPathTb;
   import cpuPkg::*;

   localparam int clkPeriod = 8;
   // About 400 stepped cycles plus four multiplies, with a wide margin
   localparam int timeoutNs = 2500 * clkPeriod;

   logic Clock, rst;
   logic extIn, rfOut, pcOut, irOut, ryOut, rzLoOut, rzHiOut, marOut;
   logic hiOut, loOut, immOut, mdrOut;
   logic pcIn, irIn, ryIn, rzIn, marIn, hiIn, loIn, mdrIn;
   logic gra, grb, grc, rin, rout, baOut, incPc, read, write, start;
   aluOp opSelect;
   logic [wordWidth-1:0] extData;
   logic finished, memFinished;
   logic [wordWidth-1:0] busValue;

   logic [wordWidth-1:0] regModel [regCount];
   logic [wordWidth-1:0] memAddr [8];
   logic [wordWidth-1:0] memData [8];
   aluOp simpleOps [8] = '{opAdd, opSub, opAnd, opOr, opShl, opShr, opNeg, opNot};

   dataPath i_dut (.*);

   initial Clock = 1'b0;
   always #(clkPeriod / 2) Clock = ~Clock;

   function automatic logic [wordWidth-1:0] aluModel(input aluOp op,
         input logic [wordWidth-1:0] a, input logic [wordWidth-1:0] b);
      case (op)
         opAdd: return a + b;
         opSub: return a - b;
         opAnd: return a & b;
         opOr: return a | b;
         opShl: return a << b[4:0];
         opShr: return a >> b[4:0];
         opNeg: return -b;
         opNot: return ~b;
         default: return '0;
      endcase
   endfunction

   // Store opcode in the top bits, then Ra, Rb and the constant
   function automatic logic [wordWidth-1:0] makeInstr(input logic [3:0] ra,
         input logic [3:0] rb, input logic [18:0] imm);
      return {5'b00011, ra, rb, imm};
   endfunction

   task automatic clearStrobes();
      {extIn, rfOut, pcOut, irOut, ryOut, rzLoOut, rzHiOut, marOut} = '0;
      {hiOut, loOut, immOut, mdrOut} = '0;
      {pcIn, irIn, ryIn, rzIn, marIn, hiIn, loIn, mdrIn} = '0;
      {gra, grb, grc, rin, rout, baOut, incPc, read, write, start} = '0;
      opSelect = opAdd;
      extData = '0;
   endtask

   task automatic nextCycle();
      @(posedge Clock);
      @(negedge Clock);
      clearStrobes();
   endtask

   task automatic driveExt(input logic [wordWidth-1:0] value);
      extIn = 1'b1;
      extData = value;
   endtask

   task automatic waitMem();
      @(negedge Clock);
      while (!memFinished) @(negedge Clock);
      clearStrobes();
   endtask

   // RZ captures on the finished cycle, so rzIn stays high until then
   task automatic runAlu(input aluOp op);
      opSelect = op;
      start = 1'b1;
      rzIn = 1'b1;
      @(negedge Clock);
      clearStrobes();
      rzIn = 1'b1;
      while (!finished) @(negedge Clock);
      nextCycle();
   endtask

   task automatic checkBus(input string testName, input logic [wordWidth-1:0] expected);
      #1;
      assert (busValue === expected)
      else begin
         $display("MISMATCH %s expected %h actual %h", testName, expected, busValue);
         $display("SIMULATION FAILED");
         $fatal(1, "bus value differs from the model");
      end
   endtask

   task automatic checkIdle(input string testName);
      #1;
      assert (!finished && !memFinished)
      else begin
         $display("%s: a completion flag is high while nothing is running", testName);
         $display("SIMULATION FAILED");
         $fatal(1, "unexpected completion flag");
      end
   endtask

   task automatic loadIr(input logic [wordWidth-1:0] instr);
      driveExt(instr);
      irIn = 1'b1;
      nextCycle();
   endtask

   task automatic loadReg(input logic [3:0] idx, input logic [wordWidth-1:0] value);
      loadIr(makeInstr(idx, 4'd0, '0));
      driveExt(value);
      gra = 1'b1;
      rin = 1'b1;
      nextCycle();
   endtask

   task automatic memWrite(input logic [wordWidth-1:0] addr, input logic [wordWidth-1:0] data);
      driveExt(addr);
      marIn = 1'b1;
      nextCycle();
      driveExt(data);
      mdrIn = 1'b1;
      nextCycle();
      write = 1'b1;
      waitMem();
   endtask

   task automatic memRead(input logic [wordWidth-1:0] addr);
      driveExt(addr);
      marIn = 1'b1;
      nextCycle();
      read = 1'b1;
      mdrIn = 1'b1;
      waitMem();
   endtask

   initial begin
      #(timeoutNs);
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired before the tests finished");
   end

   // Property failures from the bound checker end the run at once
   always @(negedge Clock) begin
      if (i_dut.props.failCount != 0) begin
         $display("SIMULATION FAILED");
         $fatal(1, "a bus or completion property failed");
      end
   end

   initial begin
      logic [wordWidth-1:0] a, b, base, instr, effAddr;
      logic [2*wordWidth-1:0] product;
      int imm;
      void'($urandom(3417));
      rst = 1'b1;
      clearStrobes();
      repeat (4) @(posedge Clock);
      @(negedge Clock);
      rst = 1'b0;

      // Write through Ra, read back through Rb
      // R0 holds a nonzero value that base addressing has to hide
      regModel[0] = $urandom | 32'h1;
      loadReg(4'd0, regModel[0]);
      for (int i = 1; i < regCount; i++) begin
         regModel[i] = $urandom;
         loadReg(4'(i), regModel[i]);
      end
      for (int i = 0; i < regCount; i++) begin
         loadIr(makeInstr(4'd0, 4'(i), '0));
         grb = 1'b1;
         rout = 1'b1;
         checkBus($sformatf("regReadback r%0d", i), regModel[i]);
         clearStrobes();
      end
      loadIr(makeInstr(4'd0, 4'd0, '0));
      grb = 1'b1;
      baOut = 1'b1;
      checkBus("baseZero", '0);
      clearStrobes();

      // Multiplies first, so the upper half of RZ is nonzero for the simple ops
      repeat (4) begin
         a = $urandom;
         b = $urandom;
         product = 64'(a) * 64'(b);
         driveExt(a);
         ryIn = 1'b1;
         nextCycle();
         driveExt(b);
         runAlu(opMul);
         rzLoOut = 1'b1;
         checkBus("mulLo", product[wordWidth-1:0]);
         clearStrobes();
         rzHiOut = 1'b1;
         checkBus("mulHi", product[2*wordWidth-1:wordWidth]);
         clearStrobes();
      end

      for (int round = 0; round < 2; round++) begin
         foreach (simpleOps[k]) begin
            a = $urandom;
            b = $urandom;
            driveExt(a);
            ryIn = 1'b1;
            nextCycle();
            driveExt(b);
            runAlu(simpleOps[k]);
            rzLoOut = 1'b1;
            checkBus($sformatf("alu %s lo", simpleOps[k].name()), aluModel(simpleOps[k], a, b));
            clearStrobes();
            rzHiOut = 1'b1;
            checkBus($sformatf("alu %s hi", simpleOps[k].name()), '0);
            clearStrobes();
         end
      end

      // Odd stride keeps the eight addresses distinct
      base = $urandom_range(memDepth - 1);
      for (int i = 0; i < 8; i++) begin
         memAddr[i] = (base + i * 61) % memDepth;
         memData[i] = $urandom;
         memWrite(memAddr[i], memData[i]);
      end
      for (int i = 0; i < 8; i++) begin
         memRead(memAddr[i]);
         mdrOut = 1'b1;
         checkBus($sformatf("memReadback %0d", i), memData[i]);
         clearStrobes();
      end

      // st R5, imm(R7) fetched from address 100
      base = 32'd300;
      regModel[7] = base;
      loadReg(4'd7, base);
      imm = int'($urandom_range(127)) - 64;
      instr = makeInstr(4'd5, 4'd7, 19'(imm));
      effAddr = base + 32'(imm);
      memWrite(32'd100, instr);
      driveExt(32'd100);
      pcIn = 1'b1;
      nextCycle();
      pcOut = 1'b1;
      marIn = 1'b1;
      incPc = 1'b1;
      nextCycle();
      read = 1'b1;
      mdrIn = 1'b1;
      waitMem();
      mdrOut = 1'b1;
      irIn = 1'b1;
      nextCycle();
      irOut = 1'b1;
      checkBus("storeFetch", instr);
      clearStrobes();
      grb = 1'b1;
      baOut = 1'b1;
      ryIn = 1'b1;
      nextCycle();
      immOut = 1'b1;
      runAlu(opAdd);
      rzLoOut = 1'b1;
      marIn = 1'b1;
      checkBus("storeAddress", effAddr);
      nextCycle();
      gra = 1'b1;
      rout = 1'b1;
      mdrIn = 1'b1;
      nextCycle();
      write = 1'b1;
      waitMem();
      memRead(effAddr);
      mdrOut = 1'b1;
      checkBus("storeData", regModel[5]);
      clearStrobes();
      pcOut = 1'b1;
      checkBus("storePc", 32'd101);
      clearStrobes();

      // Large operands leave a nonzero upper product in RZ before the reset
      driveExt($urandom | 32'h8000_0000);
      ryIn = 1'b1;
      nextCycle();
      driveExt($urandom | 32'h8000_0000);
      runAlu(opMul);

      // Reset lands in the middle of a pending read
      read = 1'b1;
      nextCycle();
      rst = 1'b1;
      repeat (2) nextCycle();
      rst = 1'b0;
      repeat (3) begin
         checkIdle("resetIdle");
         @(negedge Clock);
      end
      pcOut = 1'b1;
      checkBus("resetPc", '0);
      clearStrobes();
      irOut = 1'b1;
      checkBus("resetIr", '0);
      clearStrobes();
      rzLoOut = 1'b1;
      checkBus("resetRzLo", '0);
      clearStrobes();
      rzHiOut = 1'b1;
      checkBus("resetRzHi", '0);
      clearStrobes();
      nextCycle();

      if (i_dut.props.failCount == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         $display("SIMULATION FAILED");
         $fatal(1, "the property checker reported a failure");
      end
   end

endmodule

/* all.f */
logic/cpuPkg.sv
logic/datapathIfs.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/memoryUnit.sv
logic/dataPath.sv
bench/dataPath_props.sv
bench/dataPathTb.sv

/* Bender.yml */
package:
  name: datapath

sources:
  - logic/cpuPkg.sv
  - logic/datapathIfs.sv
  - logic/registerFile.sv
  - logic/aluUnit.sv
  - logic/memoryUnit.sv
  - logic/dataPath.sv
  - target: test
    files:
      - bench/dataPath_props.sv
      - bench/dataPathTb.sv
